// ==== hw/arb_pkg.sv ====
/* Arbitration constants and types: master count, index width and grant vector. */
`default_nettype none

package arb_pkg;

   // masters sharing the bus
   localparam int num_masters_lp = 4;

   // bits needed to name one master
   localparam int idx_width_lp = $clog2(num_masters_lp);

   // one bit per master, one-hot or all zero
   typedef logic [num_masters_lp-1:0] grant_t;

   typedef logic [idx_width_lp-1:0] idx_t;

endpackage

`default_nettype wire

// ==== hw/bus_pkg.sv ====
/* Wishbone bus widths and vector types shared by the arbiter, the memory and the top level.
   Referenced by scoped name from each file that needs them. */
`default_nettype none

package bus_pkg;

   // word address, one per memory word
   localparam int adr_width_lp = 4;

   // data path width
   localparam int dat_width_lp = 32;

   // number of words behind the bus
   localparam int mem_words_lp = 1 << adr_width_lp;

   typedef logic [adr_width_lp-1:0] adr_t;
   typedef logic [dat_width_lp-1:0] dat_t;

endpackage

`default_nettype wire

// ==== hw/encode_one_hot.sv ====
/* Encodes a one-hot vector into the index of its set bit plus a valid flag.
   Generic width; odd widths are padded up to a power of two. */
`default_nettype none

module encode_one_hot
#(
   parameter int width_p    = 8,
   parameter int lo_to_hi_p = 1
)
(
   input  wire logic [width_p-1:0]                             i,
   output      logic [((width_p > 1) ? $clog2(width_p) : 1)-1:0] addr,
   output      logic                                           v
);

   // safe index width, at least one bit
   localparam int aw_lp      = (width_p > 1) ? $clog2(width_p) : 1;
   localparam int aligned_lp = 1 << $clog2(width_p);

   if (width_p == 1)
   begin : base
      // single bit, index is always zero
      assign v    = i[0];
      assign addr = 1'b0;
   end
   else if (width_p != aligned_lp)
   begin : unaligned
      logic [aligned_lp-1:0]         padded;
      logic [$clog2(aligned_lp)-1:0] aligned_addr;

      // pad once at the top instead of at every tree node
      if (lo_to_hi_p != 0)
      begin : pad_hi
         assign padded = {{(aligned_lp-width_p){1'b0}}, i};
      end
      else
      begin : pad_lo
         assign padded = {i, {(aligned_lp-width_p){1'b0}}};
      end

      encode_one_hot
      #(
         .width_p    (aligned_lp),
         .lo_to_hi_p (lo_to_hi_p)
      )
      align_enc
      (
         .i    (padded),
         .addr (aligned_addr),
         .v    (v)
      );

      assign addr = aligned_addr[aw_lp-1:0];
   end
   else
   begin : aligned
      // each node holds {partial index, any bit set}
      logic [width_p-1:0][aw_lp:0] node;
      logic [aw_lp:0]              lo_half;
      logic [aw_lp:0]              hi_half;
      logic [1:0]                  vs;

      always_comb
      begin
         // leaves: index zero, valid is the input bit
         for (int k = 0; k < width_p; k++)
         begin
            node[k] = {{aw_lp{1'b0}}, i[k]};
         end

         // reduce pairs level by level, in place
         for (int j = 1; j <= aw_lp; j++)
         begin
            for (int k = 0; k < (width_p >> j); k++)
            begin
               lo_half = node[2*k];
               hi_half = node[2*k+1];
               vs[0]   = |lo_half;
               vs[1]   = |hi_half;
               // chosen half sets index bit j-1, stored one up past v
               node[k] = ((aw_lp+1)'(vs[lo_to_hi_p != 0]) << j) | lo_half | hi_half;
            end
         end

         {addr, v} = node[0];
      end
   end

endmodule

`default_nettype wire

// ==== hw/rr_arbiter.sv ====
/* Round-robin arbiter with a registered one-hot grant.
   The owner keeps the grant while its request (cyc) stays high. */
`default_nettype none

module rr_arbiter
(
   input  wire logic            clk_i,
   input  wire logic            arst_n,
   input  wire arb_pkg::grant_t req,
   output      arb_pkg::grant_t grant,
   output      arb_pkg::idx_t   grant_idx,
   output      logic            busy
);

   arb_pkg::grant_t grant_r;
   arb_pkg::grant_t mask;
   arb_pkg::grant_t masked_req;
   arb_pkg::grant_t candidate;
   arb_pkg::idx_t   last_owner;
   arb_pkg::idx_t   cand_idx;
   logic            cand_v;

   // only masters above the last owner get first pick
   always_comb
   begin
      for (int k = 0; k < arb_pkg::num_masters_lp; k++)
      begin
         mask[k] = (k > int'(last_owner));
      end
   end

   assign masked_req = req & mask;

   // lowest set bit of the masked set, else wrap to lowest overall
   assign candidate = (|masked_req)
      ? (masked_req & (~masked_req + arb_pkg::grant_t'(1)))
      : (req & (~req + arb_pkg::grant_t'(1)));

   encode_one_hot
   #(
      .width_p    (arb_pkg::num_masters_lp),
      .lo_to_hi_p (1)
   )
   cand_enc
   (
      .i    (candidate),
      .addr (cand_idx),
      .v    (cand_v)
   );

   // index of the current owner, busy while any grant is held
   encode_one_hot
   #(
      .width_p    (arb_pkg::num_masters_lp),
      .lo_to_hi_p (1)
   )
   grant_enc
   (
      .i    (grant_r),
      .addr (grant_idx),
      .v    (busy)
   );

   always_ff @(posedge clk_i or negedge arst_n)
   begin
      if (!arst_n)
      begin
         grant_r    <= '0;
         // start as if master 3 went last, so master 0 wins first
         last_owner <= arb_pkg::idx_t'(arb_pkg::num_masters_lp - 1);
      end
      else if (busy)
      begin
         // owner dropped cyc, free the bus for one cycle
         if (!req[grant_idx])
         begin
            grant_r <= '0;
         end
      end
      else if (cand_v)
      begin
         grant_r    <= candidate;
         last_owner <= cand_idx;
      end
   end

   assign grant = grant_r;

endmodule

`default_nettype wire

// ==== hw/wb_arbiter.sv ====
/* Arbitrates the per-master Wishbone ports and steers the owner onto the shared bus.
   Ack goes back only to the granted master; read data is broadcast. */
`default_nettype none

module wb_arbiter
(
   input  wire logic                                           clk_i,
   input  wire logic                                           arst_n,
   input  wire arb_pkg::grant_t                                m_cyc,
   input  wire arb_pkg::grant_t                                m_stb,
   input  wire arb_pkg::grant_t                                m_we,
   input  wire bus_pkg::adr_t [arb_pkg::num_masters_lp-1:0]    m_adr,
   input  wire bus_pkg::dat_t [arb_pkg::num_masters_lp-1:0]    m_dat_w,
   output      arb_pkg::grant_t                                m_ack,
   output      bus_pkg::dat_t                                  m_dat_r,
   wb_if.master                                                bus
);

   arb_pkg::grant_t grant;
   arb_pkg::idx_t   grant_idx;
   logic            busy;

   // cyc is the request, held for a whole burst
   rr_arbiter rr_arbiter_i
   (
      .clk_i     (clk_i),
      .arst_n    (arst_n),
      .req       (m_cyc),
      .grant     (grant),
      .grant_idx (grant_idx),
      .busy      (busy)
   );

   // no owner, keep the bus quiet
   assign bus.cyc = busy & m_cyc[grant_idx];
   assign bus.stb = busy & m_stb[grant_idx];

   // payload follows the owner index
   assign bus.we    = m_we[grant_idx];
   assign bus.adr   = m_adr[grant_idx];
   assign bus.dat_w = m_dat_w[grant_idx];

   // ack only on the owner's bit
   assign m_ack   = grant & {arb_pkg::num_masters_lp{bus.ack}};
   assign m_dat_r = bus.dat_r;

endmodule

`default_nettype wire

// ==== hw/wb_if.sv ====
/* Wishbone classic bus between the arbiter (master side) and the memory (slave side). */
`default_nettype none

interface wb_if;

   // request side, driven by the arbiter
   logic          cyc;
   logic          stb;
   logic          we;
   bus_pkg::adr_t adr;
   bus_pkg::dat_t dat_w;

   // response side, driven by the memory
   logic          ack;
   bus_pkg::dat_t dat_r;

   modport master
   (
      output cyc, stb, we, adr, dat_w,
      input  ack, dat_r
   );

   modport slave
   (
      input  cyc, stb, we, adr, dat_w,
      output ack, dat_r
   );

endinterface

`default_nettype wire

// ==== hw/wb_ram.sv ====
/* Wishbone classic slave register memory, one registered ack per strobe. */
`default_nettype none

module wb_ram
(
   input  wire logic clk_i,
   input  wire logic arst_n,
   wb_if.slave       bus
);

   bus_pkg::dat_t mem [bus_pkg::mem_words_lp];
   bus_pkg::dat_t dat_r_r;
   logic          ack_r;
   logic          access;

   // new transfer, skip the cycle the ack is already out
   assign access = bus.cyc & bus.stb & ~ack_r;

   always_ff @(posedge clk_i or negedge arst_n)
   begin
      if (!arst_n)
      begin
         ack_r <= 1'b0;
      end
      else
      begin
         ack_r <= access;
      end
   end

   // storage and read word
   always_ff @(posedge clk_i)
   begin
      if (access)
      begin
         if (bus.we)
         begin
            mem[bus.adr] <= bus.dat_w;
         end
         else
         begin
            dat_r_r <= mem[bus.adr];
         end
      end
   end

   assign bus.ack   = ack_r;
   assign bus.dat_r = dat_r_r;

endmodule

`default_nettype wire

// ==== hw/wb_shared_bus.sv ====
/* Top level: four Wishbone masters on plain ports share one register memory.
   Each per-master signal is a packed array indexed by master. */
`default_nettype none

module wb_shared_bus
(
   input  wire logic                                        clk_i,
   input  wire logic                                        arst_n,
   input  wire arb_pkg::grant_t                             m_cyc,
   input  wire arb_pkg::grant_t                             m_stb,
   input  wire arb_pkg::grant_t                             m_we,
   input  wire bus_pkg::adr_t [arb_pkg::num_masters_lp-1:0] m_adr,
   input  wire bus_pkg::dat_t [arb_pkg::num_masters_lp-1:0] m_dat_w,
   output      arb_pkg::grant_t                             m_ack,
   output      bus_pkg::dat_t                               m_dat_r
);

   // shared bus between arbiter and memory
   wb_if bus_if ();

   wb_arbiter wb_arbiter_i
   (
      .clk_i   (clk_i),
      .arst_n  (arst_n),
      .m_cyc   (m_cyc),
      .m_stb   (m_stb),
      .m_we    (m_we),
      .m_adr   (m_adr),
      .m_dat_w (m_dat_w),
      .m_ack   (m_ack),
      .m_dat_r (m_dat_r),
      .bus     (bus_if.master)
   );

   wb_ram wb_ram_i
   (
      .clk_i  (clk_i),
      .arst_n (arst_n),
      .bus    (bus_if.slave)
   );

endmodule

`default_nettype wire

// ==== list.f ====
hw/bus_pkg.sv
hw/arb_pkg.sv
hw/wb_if.sv
hw/encode_one_hot.sv
hw/rr_arbiter.sv
hw/wb_arbiter.sv
hw/wb_ram.sv
hw/wb_shared_bus.sv
sim/clk_gen.sv
sim/tb_shared_bus.sv

// ==== run.sh ====
#!/bin/sh
# build and run the shared bus testbench with Verilator, then grade the log
rm -f sim.log
verilator --binary --timing --top-module tb_shared_bus -f list.f -o tb_shared_bus \
   > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_shared_bus > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0

// ==== sim/clk_gen.sv ====
/* Free-running testbench clock with a period of 4 time units. */
`default_nettype none

module clk_gen
(
   output logic clk
);

   // half of the 4-unit period
   localparam int half_period_lp = 2;

   initial
   begin
      clk = 1'b0;
   end

   always #half_period_lp clk = ~clk;

endmodule

`default_nettype wire

// ==== sim/tb_shared_bus.sv ====
/* Testbench for the four-master shared Wishbone bus: directed and LFSR traffic.
   A reference arbiter and a memory model check ack steering, rotation and read data. */
`default_nettype none

module tb_shared_bus;

   localparam int nm_lp         = arb_pkg::num_masters_lp;
   localparam int rand_xfers_lp = 40;
   // 2 single transfers, 12 in the rotation rounds, 7 in the burst phase
   localparam int xfer_total_lp = 21 + rand_xfers_lp;
   localparam int watchdog_lp   = xfer_total_lp * nm_lp * 8 + 100;

   // one queued transfer; last drops cyc after its ack
   typedef struct packed
   {
      logic          last;
      logic          we;
      bus_pkg::adr_t adr;
      bus_pkg::dat_t dat;
   } job_t;

   logic                      clk;
   logic                      arst_n;
   arb_pkg::grant_t           m_cyc;
   arb_pkg::grant_t           m_stb;
   arb_pkg::grant_t           m_we;
   bus_pkg::adr_t [nm_lp-1:0] m_adr;
   bus_pkg::dat_t [nm_lp-1:0] m_dat_w;
   arb_pkg::grant_t           m_ack;
   bus_pkg::dat_t             m_dat_r;

   // per-master transfer queues and the order in which acks arrived
   job_t          jobs [nm_lp][$];
   int            ack_log [$];

   // memory model, words valid once written
   bus_pkg::dat_t                    model_mem [bus_pkg::mem_words_lp];
   logic [bus_pkg::mem_words_lp-1:0] model_ok = '0;

   // reference arbiter state, -1 means no owner
   int            owner      = -1;
   int            last_owner = nm_lp - 1;
   logic [15:0]   lfsr       = 16'd29;

   clk_gen clk_gen_i
   (
      .clk (clk)
   );

   wb_shared_bus wb_shared_bus_i
   (
      .clk_i   (clk),
      .arst_n  (arst_n),
      .m_cyc   (m_cyc),
      .m_stb   (m_stb),
      .m_we    (m_we),
      .m_adr   (m_adr),
      .m_dat_w (m_dat_w),
      .m_ack   (m_ack),
      .m_dat_r (m_dat_r)
   );

   // next owner in rotation after last, -1 when nobody requests
   function automatic int next_owner(input int last, input arb_pkg::grant_t req);
      int cand;
      next_owner = -1;
      // walk from the far end so the nearest requester is kept
      for (int k = nm_lp; k >= 1; k--)
      begin
         cand = (last + k) % nm_lp;
         if (req[cand])
         begin
            next_owner = cand;
         end
      end
   endfunction

   // 16-bit Fibonacci LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // one LFSR step per bit taken
   task automatic take_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int k = 0; k < n; k++)
      begin
         lfsr = lfsr_next(lfsr);
         val  = {val[30:0], lfsr[0]};
      end
   endtask

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("Fail at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
         $display("Simulation finished: FAIL");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   // payload of a master's next transfer
   task automatic present(input int m, input job_t j);
      m_we[m]    <= j.we;
      m_adr[m]   <= j.adr;
      m_dat_w[m] <= j.dat;
   endtask

   // steps all job queues once per falling edge until every master is idle
   task automatic run_jobs();
      job_t cur;
      logic pending;
      pending = 1'b1;
      while (pending)
      begin
         @(negedge clk);
         pending = 1'b0;
         for (int m = 0; m < nm_lp; m++)
         begin
            if (m_cyc[m] && m_ack[m])
            begin
               cur = jobs[m].pop_front();
               // end of burst, release the bus
               if (cur.last || jobs[m].size() == 0)
               begin
                  m_cyc[m] <= 1'b0;
                  m_stb[m] <= 1'b0;
               end
               else
               begin
                  present(m, jobs[m][0]);
               end
            end
            else if (!m_cyc[m] && jobs[m].size() != 0)
            begin
               present(m, jobs[m][0]);
               m_cyc[m] <= 1'b1;
               m_stb[m] <= 1'b1;
            end
            if (m_cyc[m] || jobs[m].size() != 0)
            begin
               pending = 1'b1;
            end
         end
      end
   endtask

   // one transfer on an idle bus, ack expected two cycles after the request
   task automatic single_xfer(input int m, input logic we, input bus_pkg::adr_t adr,
                              input bus_pkg::dat_t dat, output bus_pkg::dat_t rdata);
      int cycles;
      @(negedge clk);
      m_we[m]    <= we;
      m_adr[m]   <= adr;
      m_dat_w[m] <= dat;
      m_cyc[m]   <= 1'b1;
      m_stb[m]   <= 1'b1;
      cycles = 0;
      do
      begin
         @(negedge clk);
         cycles++;
      end
      while (!m_ack[m]);
      rdata = m_dat_r;
      check("ack latency on an idle bus", cycles, 2);
      m_cyc[m] <= 1'b0;
      m_stb[m] <= 1'b0;
      @(negedge clk);
   endtask

   // compares acks and read data, then advances the reference arbiter
   // inputs still hold what the DUT saw at the rising edge just past
   always @(negedge clk)
   begin : compare
      int prev;
      int acked;
      if (arst_n)
      begin
         prev = owner;
         check("ack on a master without cyc", 32'(m_ack & ~m_cyc), 0);
         if (m_ack != '0)
         begin
            check("ack not on the predicted owner", 32'(m_ack),
                  (prev < 0) ? 0 : (32'(1) << prev));
            // master the DUT actually acked
            acked = -1;
            for (int k = 0; k < nm_lp; k++)
            begin
               if (m_ack[k])
               begin
                  acked = k;
               end
            end
            ack_log.push_back(acked);
            if (m_we[prev])
            begin
               model_mem[m_adr[prev]] = m_dat_w[prev];
               model_ok[m_adr[prev]]  = 1'b1;
            end
            else if (model_ok[m_adr[prev]])
            begin
               check("read data", m_dat_r, model_mem[m_adr[prev]]);
            end
         end
         // owner keeps the bus until cyc drops, then one free cycle
         if (owner >= 0)
         begin
            if (!m_cyc[owner])
            begin
               owner = -1;
            end
         end
         else
         begin
            owner = next_owner(last_owner, m_cyc);
            if (owner >= 0)
            begin
               last_owner = owner;
            end
         end
      end
   end

   initial
   begin
      bus_pkg::dat_t rdata;
      logic [31:0]   r;
      job_t          j;
      int            mark;
      int            b;
      arst_n  = 1'b0;
      m_cyc   = '0;
      m_stb   = '0;
      m_we    = '0;
      m_adr   = '0;
      m_dat_w = '0;
      repeat (3) @(negedge clk);
      arst_n <= 1'b1;

      // idle bus after reset
      repeat (8)
      begin
         @(negedge clk);
         check("ack while no master requests", 32'(m_ack), 0);
      end

      // master 3 alone, write then read back
      single_xfer(3, 1'b1, 4'h5, 32'hcafe_0015, rdata);
      single_xfer(3, 1'b0, 4'h5, 32'h0, rdata);
      check("read back of written word", rdata, 32'hcafe_0015);

      // all four at once, three rounds of single transfers
      mark = ack_log.size();
      for (int rnd = 0; rnd < 3; rnd++)
      begin
         for (int m = 0; m < nm_lp; m++)
         begin
            j.last = 1'b1;
            j.we   = 1'b1;
            j.adr  = bus_pkg::adr_t'(rnd * nm_lp + m);
            j.dat  = 32'h1000_0000 * (m + 1) + 32'(rnd);
            jobs[m].push_back(j);
         end
      end
      run_jobs();
      for (int k = 0; k < nm_lp; k++)
      begin
         check("first round ack order", ack_log[mark + k], k);
      end

      // burst of 4 from the next master in rotation, the rest wait
      mark = ack_log.size();
      b    = next_owner(last_owner, '1);
      for (int k = 0; k < 4; k++)
      begin
         j.last = (k == 3);
         j.we   = (k < 2);
         j.adr  = bus_pkg::adr_t'(12 + k % 2);
         j.dat  = 32'hb000_0000 + 32'(k);
         jobs[b].push_back(j);
      end
      for (int m = 0; m < nm_lp; m++)
      begin
         if (m != b)
         begin
            j.last = 1'b1;
            j.we   = 1'b1;
            j.adr  = 4'he;
            j.dat  = 32'hd000_0000 + 32'(m);
            jobs[m].push_back(j);
         end
      end
      run_jobs();
      for (int k = 0; k < 4; k++)
      begin
         check("burst owner acked first", ack_log[mark + k], b);
      end

      // LFSR picks master, direction, address, data and burst end
      for (int n = 0; n < rand_xfers_lp; n++)
      begin
         take_bits(arb_pkg::idx_width_lp, r);
         b = int'(r[arb_pkg::idx_width_lp-1:0]);
         take_bits(1, r);
         j.we = r[0];
         take_bits(bus_pkg::adr_width_lp, r);
         j.adr = bus_pkg::adr_t'(r);
         take_bits(bus_pkg::dat_width_lp, r);
         j.dat = r;
         take_bits(1, r);
         j.last = r[0];
         jobs[b].push_back(j);
      end
      run_jobs();

      $display("Simulation finished: PASS");
      $finish;
   end

   // ends a run that stops making progress
   initial
   begin
      repeat (watchdog_lp) @(posedge clk);
      $display("Error: the bus hung, no end of test after %0d cycles", watchdog_lp);
      $display("Simulation finished: FAIL");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire
